//--- hw/radio_pkg.sv
package radio_pkg;

   ////////////////////
   // Datapath and SPI sizing

   localparam int dac_width = 14;       // One DAC word
   localparam int spi_slaves = 4;       // TX db, RX db, codec, clock gen
   localparam int spi_bits = 16;        // Bits per transfer
   localparam int spi_half = 2;         // clk_2x cycles per half SCLK
   localparam int fifo_depth = 8;       // Sample pairs
   localparam int apb_addr_width = 8;

   ////////////////////
   // Register map

   localparam logic [apb_addr_width-1:0] addr_spi_cmd = 8'h00;
   localparam logic [apb_addr_width-1:0] addr_spi_status = 8'h04;
   localparam logic [apb_addr_width-1:0] addr_spi_rdata = 8'h08;
   localparam logic [apb_addr_width-1:0] addr_tx_sample = 8'h0C;
   localparam logic [apb_addr_width-1:0] addr_tx_ctrl = 8'h10;

   ////////////////////
   // APB write word

   // The same 32-bit word is a SPI command or an I/Q pair
   // depending on the address it is written to
   typedef union packed
   {
      struct packed
      {
         logic [13:0] spare;
         logic [1:0]  chip;   // Index into sen
         logic [15:0] data;   // Shifted out MSB first
      } spi_cmd;
      struct packed
      {
         logic [3:0]           spare;
         logic [dac_width-1:0] i_word;
         logic [dac_width-1:0] q_word;
      } iq;
   } reg_word_u;

endpackage

//--- hw/apb_regs.sv
`timescale 1ns/100ps

module apb_regs
(
   input  logic                                clk_2x,
   input  logic                                rst_n,
   input  logic                                psel,
   input  logic                                penable,
   input  logic                                pwrite,
   input  logic [radio_pkg::apb_addr_width-1:0] paddr,
   input  logic [31:0]                         pwdata,
   output logic [31:0]                         prdata,
   output logic                                pready,
   output logic                                pslverr,
   output logic                                spi_start,
   output logic [1:0]                          spi_sel,
   output logic [radio_pkg::spi_bits-1:0]      spi_wdata,
   input  logic                                spi_busy,
   input  logic [radio_pkg::spi_bits-1:0]      spi_rdata,
   output logic                                fifo_push,
   output logic [2*radio_pkg::dac_width-1:0]   fifo_wdata,
   input  logic                                fifo_full,
   output logic                                tx_enable,
   input  logic                                underrun_pulse,
   output logic                                underrun_flag
);

   radio_pkg::reg_word_u wword;
   logic access;
   logic hit_cmd;
   logic hit_status;
   logic hit_rdata;
   logic hit_sample;
   logic hit_ctrl;
   logic mapped;
   logic err;
   logic wr_ok;

   ////////////////////
   // Address decode and errors

   assign wword = pwdata;
   assign access = psel & penable;   // Access phase of a transfer

   assign hit_cmd = (paddr == radio_pkg::addr_spi_cmd);
   assign hit_status = (paddr == radio_pkg::addr_spi_status);
   assign hit_rdata = (paddr == radio_pkg::addr_spi_rdata);
   assign hit_sample = (paddr == radio_pkg::addr_tx_sample);
   assign hit_ctrl = (paddr == radio_pkg::addr_tx_ctrl);
   assign mapped = hit_cmd | hit_status | hit_rdata | hit_sample | hit_ctrl;

   // A start still in flight counts as busy
   assign err = ~mapped
              | (pwrite & hit_cmd & (spi_busy | spi_start))
              | (pwrite & hit_sample & fifo_full);

   assign pready = access;           // No wait states
   assign pslverr = access & err;
   assign wr_ok = access & pwrite & ~err;

   // Sample goes straight into the FIFO on the closing edge
   assign fifo_push = wr_ok & hit_sample;
   assign fifo_wdata = {wword.iq.i_word, wword.iq.q_word};

   ////////////////////
   // Control state

   always_ff @(posedge clk_2x)
   begin
      if (!rst_n)
      begin
         spi_start <= 1'b0;
         tx_enable <= 1'b0;
         underrun_flag <= 1'b0;
      end
      else
      begin
         spi_start <= wr_ok & hit_cmd;   // Single-cycle pulse
         if (wr_ok & hit_ctrl)
            tx_enable <= pwdata[0];
         if (underrun_pulse)
            underrun_flag <= 1'b1;       // New underrun wins over clear
         else if (wr_ok & hit_ctrl & pwdata[2])
            underrun_flag <= 1'b0;
      end
   end

   // Command held for the SPI master
   always_ff @(posedge clk_2x)
   begin
      if (wr_ok & hit_cmd)
      begin
         spi_sel <= wword.spi_cmd.chip;
         spi_wdata <= wword.spi_cmd.data;
      end
   end

   ////////////////////
   // Read data

   always_comb
   begin
      prdata = '0;
      case (paddr)
         radio_pkg::addr_spi_status: prdata[0] = spi_busy;
         radio_pkg::addr_spi_rdata:  prdata[radio_pkg::spi_bits-1:0] = spi_rdata;
         radio_pkg::addr_tx_ctrl:    prdata[2:0] = {underrun_flag, ~fifo_full, tx_enable};
         default:                    prdata = '0;
      endcase
   end

endmodule

//--- hw/spi_master.sv
`timescale 1ns/100ps

module spi_master
(
   input  logic                             clk_2x,
   input  logic                             rst_n,
   input  logic                             spi_start,
   input  logic [1:0]                       spi_sel,
   input  logic [radio_pkg::spi_bits-1:0]   spi_wdata,
   input  logic [radio_pkg::spi_slaves-1:0] miso_in,
   output logic                             spi_busy,
   output logic [radio_pkg::spi_bits-1:0]   spi_rdata,
   output logic [radio_pkg::spi_slaves-1:0] sen,
   output logic [radio_pkg::spi_slaves-1:0] sclk_out,
   output logic [radio_pkg::spi_slaves-1:0] mosi_out
);

   logic                                 busy_q;
   logic                                 sclk_q;
   logic [$clog2(radio_pkg::spi_half)-1:0] div_cnt;
   logic [$clog2(radio_pkg::spi_bits):0]   bit_cnt;
   logic [radio_pkg::spi_slaves-1:0]     sen_q;
   logic [radio_pkg::spi_bits-1:0]       shift_q;
   logic [radio_pkg::spi_bits-1:0]       rdata_q;
   logic                                 miso_q;
   logic                                 miso_sel;
   logic                                 half_end;

   assign half_end = (div_cnt == radio_pkg::spi_half - 1);

   ////////////////////
   // Sequencer

   always_ff @(posedge clk_2x)
   begin
      if (!rst_n)
      begin
         busy_q <= 1'b0;
         sclk_q <= 1'b0;
         div_cnt <= '0;
         bit_cnt <= '0;
         sen_q <= '1;
         rdata_q <= '0;
      end
      else if (!busy_q)
      begin
         if (spi_start)
         begin
            busy_q <= 1'b1;
            sclk_q <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
            sen_q <= '1;
            sen_q[spi_sel] <= 1'b0;   // Only the addressed chip
         end
      end
      else
      begin
         div_cnt <= half_end ? '0 : div_cnt + 1'b1;
         if (half_end)
         begin
            if (bit_cnt == radio_pkg::spi_bits)
            begin
               // Trailing low half done, release the chip
               busy_q <= 1'b0;
               sen_q <= '1;
               rdata_q <= shift_q;
            end
            else if (!sclk_q)
               sclk_q <= 1'b1;
            else
            begin
               sclk_q <= 1'b0;
               bit_cnt <= bit_cnt + 1'b1;
            end
         end
      end
   end

   ////////////////////
   // Shift register

   // MISO is captured at the rise and enters the register at the fall,
   // so MOSI only moves on the falling edge
   always_ff @(posedge clk_2x)
   begin
      if (!busy_q && spi_start)
         shift_q <= spi_wdata;
      else if (busy_q && half_end && bit_cnt != radio_pkg::spi_bits)
      begin
         if (!sclk_q)
            miso_q <= miso_sel;                                    // Rising SCLK
         else
            shift_q <= {shift_q[radio_pkg::spi_bits-2:0], miso_q};   // Falling SCLK
      end
   end

   ////////////////////
   // Lane gating

   always_comb
   begin
      miso_sel = 1'b0;
      for (int k = 0; k < radio_pkg::spi_slaves; k++)
      begin
         sclk_out[k] = sclk_q & ~sen_q[k];
         mosi_out[k] = shift_q[radio_pkg::spi_bits-1] & ~sen_q[k];
         miso_sel = miso_sel | (miso_in[k] & ~sen_q[k]);   // Selected chip only
      end
   end

   assign sen = sen_q;
   assign spi_busy = busy_q;
   assign spi_rdata = rdata_q;

endmodule

//--- hw/tx_sample_fifo.sv
`timescale 1ns/100ps

module tx_sample_fifo
(
   input  logic                              clk_2x,
   input  logic                              rst_n,
   input  logic                              push,
   input  logic [2*radio_pkg::dac_width-1:0] wdata,
   input  logic                              pop,
   output logic [2*radio_pkg::dac_width-1:0] rdata,
   output logic                              full,
   output logic                              empty
);

   logic [2*radio_pkg::dac_width-1:0]       mem [radio_pkg::fifo_depth];
   logic [$clog2(radio_pkg::fifo_depth)-1:0] wr_ptr;
   logic [$clog2(radio_pkg::fifo_depth)-1:0] rd_ptr;
   logic [$clog2(radio_pkg::fifo_depth):0]   count;
   logic                                    do_push;
   logic                                    do_pop;

   assign full = (count == radio_pkg::fifo_depth);
   assign empty = (count == 0);

   // Requests beyond the limits are dropped
   assign do_push = push & ~full;
   assign do_pop = pop & ~empty;

   ////////////////////
   // Storage

   always_ff @(posedge clk_2x)
   begin
      if (do_push)
         mem[wr_ptr] <= wdata;
   end

   assign rdata = mem[rd_ptr];   // Head of queue, no read latency

   ////////////////////
   // Pointers and occupancy

   always_ff @(posedge clk_2x)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= (wr_ptr == radio_pkg::fifo_depth - 1) ? '0 : wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= (rd_ptr == radio_pkg::fifo_depth - 1) ? '0 : rd_ptr + 1'b1;

         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // Idle or both at once
         endcase
      end
   end

endmodule

//--- hw/dac_interleave.sv
`timescale 1ns/100ps

module dac_interleave
(
   input  logic                              clk_2x,
   input  logic                              rst_n,
   input  logic                              tx_enable,
   input  logic [2*radio_pkg::dac_width-1:0] fifo_rdata,
   input  logic                              fifo_empty,
   output logic                              fifo_pop,
   output logic [radio_pkg::dac_width-1:0]   tx_data,
   output logic                              tx_sync,
   output logic                              underrun_pulse
);

   logic                            phase_q;   // 0 selects the I slot
   logic [radio_pkg::dac_width-1:0] q_hold;
   logic                            slot_i;

   assign slot_i = ~phase_q;
   assign fifo_pop = slot_i & tx_enable & ~fifo_empty;

   always_ff @(posedge clk_2x)
   begin
      if (!rst_n)
      begin
         phase_q <= 1'b1;   // Odd slot first so sync toggles from reset
         q_hold <= '0;
         tx_data <= '0;
         tx_sync <= 1'b0;
         underrun_pulse <= 1'b0;
      end
      else
      begin
         phase_q <= ~phase_q;
         underrun_pulse <= slot_i & tx_enable & fifo_empty;
         if (slot_i)
         begin
            tx_sync <= 1'b0;   // Low marks the I word
            if (fifo_pop)
            begin
               tx_data <= fifo_rdata[2*radio_pkg::dac_width-1:radio_pkg::dac_width];
               q_hold <= fifo_rdata[radio_pkg::dac_width-1:0];
            end
            else
            begin
               // Disabled or starved, send silence
               tx_data <= '0;
               q_hold <= '0;
            end
         end
         else
         begin
            tx_sync <= 1'b1;
            tx_data <= q_hold;
         end
      end
   end

endmodule

//--- hw/radio_io_top.sv
`timescale 1ns/100ps

module radio_io_top
(
   input  logic                                clk_2x,
   input  logic                                rst_n,
   input  logic                                psel,
   input  logic                                penable,
   input  logic                                pwrite,
   input  logic [radio_pkg::apb_addr_width-1:0] paddr,
   input  logic [31:0]                         pwdata,
   input  logic [radio_pkg::spi_slaves-1:0]    miso_in,
   output logic [31:0]                         prdata,
   output logic                                pready,
   output logic                                pslverr,
   output logic [radio_pkg::spi_slaves-1:0]    sen,
   output logic [radio_pkg::spi_slaves-1:0]    sclk_out,
   output logic [radio_pkg::spi_slaves-1:0]    mosi_out,
   output logic [radio_pkg::dac_width-1:0]     tx_data,
   output logic                                tx_sync,
   output logic                                tx_have_space,
   output logic                                tx_underrun
);

   logic                              spi_start;
   logic [1:0]                        spi_sel;
   logic [radio_pkg::spi_bits-1:0]    spi_wdata;
   logic                              spi_busy;
   logic [radio_pkg::spi_bits-1:0]    spi_rdata;
   logic                              fifo_push;
   logic                              fifo_pop;
   logic [2*radio_pkg::dac_width-1:0] fifo_wdata;
   logic [2*radio_pkg::dac_width-1:0] fifo_rdata;
   logic                              fifo_full;
   logic                              fifo_empty;
   logic                              tx_enable;
   logic                              underrun_pulse;

   assign tx_have_space = ~fifo_full;   // Flow-control pin to host

   ////////////////////
   // Register block

   apb_regs i_apb_regs
   (
      .clk_2x(clk_2x), .rst_n(rst_n),
      .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
      .prdata(prdata), .pready(pready), .pslverr(pslverr),
      .spi_start(spi_start), .spi_sel(spi_sel), .spi_wdata(spi_wdata),
      .spi_busy(spi_busy), .spi_rdata(spi_rdata),
      .fifo_push(fifo_push), .fifo_wdata(fifo_wdata), .fifo_full(fifo_full),
      .tx_enable(tx_enable), .underrun_pulse(underrun_pulse),
      .underrun_flag(tx_underrun)
   );

   ////////////////////
   // SPI with lane fan-out

   spi_master i_spi_master
   (
      .clk_2x(clk_2x), .rst_n(rst_n),
      .spi_start(spi_start), .spi_sel(spi_sel), .spi_wdata(spi_wdata),
      .miso_in(miso_in), .spi_busy(spi_busy), .spi_rdata(spi_rdata),
      .sen(sen), .sclk_out(sclk_out), .mosi_out(mosi_out)
   );

   ////////////////////
   // Transmit path

   tx_sample_fifo i_tx_sample_fifo
   (
      .clk_2x(clk_2x), .rst_n(rst_n),
      .push(fifo_push), .wdata(fifo_wdata), .pop(fifo_pop),
      .rdata(fifo_rdata), .full(fifo_full), .empty(fifo_empty)
   );

   dac_interleave i_dac_interleave
   (
      .clk_2x(clk_2x), .rst_n(rst_n),
      .tx_enable(tx_enable), .fifo_rdata(fifo_rdata), .fifo_empty(fifo_empty),
      .fifo_pop(fifo_pop), .tx_data(tx_data), .tx_sync(tx_sync),
      .underrun_pulse(underrun_pulse)
   );

endmodule

//--- verif/radio_io_sva.sv
`timescale 1ns/100ps

module radio_io_sva
(
   input logic                             clk_2x,
   input logic                             rst_n,
   input logic                             psel,
   input logic                             penable,
   input logic                             pready,
   input logic [radio_pkg::spi_slaves-1:0] sen,
   input logic [radio_pkg::spi_slaves-1:0] sclk_out,
   input logic [radio_pkg::spi_slaves-1:0] mosi_out,
   input logic                             tx_sync
);

   ////////////////////
   // SPI lanes

   one_select: assert property (@(posedge clk_2x) disable iff (!rst_n) $onehot0(~sen))
      else $error("More than one SPI select low");

   quiet_lanes: assert property (@(posedge clk_2x) disable iff (!rst_n)
                                 ((sclk_out | mosi_out) & sen) == '0)
      else $error("SCLK or MOSI active on a deselected lane");

   ////////////////////
   // APB and DAC

   ready_in_access: assert property (@(posedge clk_2x) disable iff (!rst_n)
                                     psel && penable |-> pready)
      else $error("pready low in an APB access cycle");

   // Interleave phase runs freely once out of reset
   sync_toggles: assert property (@(posedge clk_2x) disable iff (!rst_n)
                                  $past(rst_n) |-> tx_sync != $past(tx_sync))
      else $error("tx_sync held for two cycles");

endmodule

bind radio_io_top radio_io_sva i_radio_io_sva (.*);

//--- verif/radio_io_tb.sv
`timescale 1ns/100ps

module radio_io_tb;

   logic                                 clk_2x;
   logic                                 rst_n;
   logic                                 psel;
   logic                                 penable;
   logic                                 pwrite;
   logic [radio_pkg::apb_addr_width-1:0] paddr;
   logic [31:0]                          pwdata;
   logic [radio_pkg::spi_slaves-1:0]     miso_in;
   logic [31:0]                          prdata;
   logic                                 pready;
   logic                                 pslverr;
   logic [radio_pkg::spi_slaves-1:0]     sen;
   logic [radio_pkg::spi_slaves-1:0]     sclk_out;
   logic [radio_pkg::spi_slaves-1:0]     mosi_out;
   logic [radio_pkg::dac_width-1:0]      tx_data;
   logic                                 tx_sync;
   logic                                 tx_have_space;
   logic                                 tx_underrun;

   int seed = 94467;
   radio_pkg::reg_word_u sent_pairs[$];   // Accepted but not yet on the DAC

   // SPI chip model
   logic [radio_pkg::spi_bits-1:0]   spi_resp;
   logic [radio_pkg::spi_bits-1:0]   rx_word;
   logic [radio_pkg::spi_slaves-1:0] sen_low_seen;
   logic                             idle_busy;   // Activity on a deselected lane
   logic [radio_pkg::spi_slaves-1:0] sen_prev;
   logic [radio_pkg::spi_slaves-1:0] sclk_prev;
   int                               tx_pos;
   int                               lane;

   // DAC comparer
   radio_pkg::reg_word_u cur_pair;
   logic                 q_pending;
   logic                 prev_sync;
   logic                 have_prev;

   radio_io_top i_radio_io_top (.*);

   always #20 clk_2x = ~clk_2x;

   ////////////////////
   // Reporting and checks

   task automatic abort_run(input string why);
      $display("%s", why);
      $display(">>> FAIL");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic check_word(input string name, input radio_pkg::reg_word_u got,
                             input radio_pkg::reg_word_u exp);
      if (got !== exp)
         abort_run($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic check_dac(input string name, input logic [radio_pkg::dac_width-1:0] got,
                            input logic [radio_pkg::dac_width-1:0] exp);
      if (got !== exp)
         abort_run($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
         abort_run($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   ////////////////////
   // Reference functions

   // I goes out first with sync low and Q follows
   function automatic logic [radio_pkg::dac_width-1:0] expected_word(
      input radio_pkg::reg_word_u pair, input logic q_slot);
      return q_slot ? pair.iq.q_word : pair.iq.i_word;
   endfunction

   // Mode 0 with MSB first on the wire
   function automatic logic [radio_pkg::spi_bits-1:0] spi_expected(
      input logic [radio_pkg::spi_bits-1:0] resp);
      logic [radio_pkg::spi_bits-1:0] word;
      word = '0;
      for (int i = radio_pkg::spi_bits - 1; i >= 0; i--)
         word = {word[radio_pkg::spi_bits-2:0], resp[i]};
      return word;
   endfunction

   ////////////////////
   // Bus tasks

   task automatic apb_transfer(input logic wr, input logic [7:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err);
      int n;
      @(posedge clk_2x);
      psel <= 1'b1;   // Setup cycle
      penable <= 1'b0;
      pwrite <= wr;
      paddr <= addr;
      pwdata <= wdata;
      @(posedge clk_2x);
      penable <= 1'b1;
      n = 0;
      do
      begin
         @(posedge clk_2x);
         n++;
         if (n > 8)
            abort_run("APB access cycle never saw pready");
      end
      while (!pready);
      rdata = prdata;
      err = pslverr;
      psel <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic write_pair(input logic accept);
      radio_pkg::reg_word_u w;
      logic [31:0] rd;
      logic err;
      w = $random(seed);
      w.iq.spare = '0;
      if (w.iq.i_word == '0)
         w.iq.i_word = 1;   // Non-zero I marks a pair in the stream
      apb_transfer(1'b1, radio_pkg::addr_tx_sample, w, rd, err);
      check_bit("pslverr", err, ~accept);
      if (accept)
         sent_pairs.push_back(w);
   endtask

   task automatic wait_spi_idle();
      logic [31:0] rd;
      logic err;
      int n;
      n = 0;
      do
      begin
         apb_transfer(1'b0, radio_pkg::addr_spi_status, '0, rd, err);
         n++;
         if (n > 50)
            abort_run("SPI busy never cleared");
      end
      while (rd[0]);
   endtask

   task automatic wait_drained();
      int n;
      n = 0;
      while (sent_pairs.size() != 0)
      begin
         @(posedge clk_2x);
         n++;
         if (n > 200)
            abort_run("DAC did not send all written samples");
      end
   endtask

   task automatic wait_underrun();
      int n;
      n = 0;
      while (!tx_underrun)
      begin
         @(posedge clk_2x);
         n++;
         if (n > 20)
            abort_run("No underrun after the FIFO drained");
      end
   endtask

   // Disable first so a late underrun cannot beat the clear
   task automatic stop_tx();
      logic [31:0] rd;
      logic err;
      apb_transfer(1'b1, radio_pkg::addr_tx_ctrl, 32'h0, rd, err);
      check_bit("pslverr", err, 1'b0);
      apb_transfer(1'b1, radio_pkg::addr_tx_ctrl, 32'h4, rd, err);
      check_bit("pslverr", err, 1'b0);
      apb_transfer(1'b0, radio_pkg::addr_tx_ctrl, '0, rd, err);
      check_word("prdata", rd, 32'h2);
      check_bit("tx_underrun", tx_underrun, 1'b0);
   endtask

   ////////////////////
   // SPI chip model

   always @(posedge clk_2x)
   begin
      for (int k = 0; k < radio_pkg::spi_slaves; k++)
         if (!sen[k])
            lane = k;
      if (!rst_n)
      begin
         miso_in <= '0;
         sen_prev <= '1;
         sclk_prev <= '0;
         rx_word <= '0;
         sen_low_seen <= '0;
         idle_busy <= 1'b0;
         tx_pos <= 0;
      end
      else
      begin
         if (sen == '1)
            miso_in <= '0;
         else if (sen_prev == '1)
         begin
            // First bit ready before the first rising SCLK
            sen_low_seen <= ~sen;
            idle_busy <= |((sclk_out | mosi_out) & sen);
            rx_word <= '0;
            miso_in <= '0;
            miso_in[lane] <= spi_resp[radio_pkg::spi_bits-1];
            tx_pos <= radio_pkg::spi_bits - 2;
         end
         else
         begin
            sen_low_seen <= sen_low_seen | ~sen;
            idle_busy <= idle_busy | (|((sclk_out | mosi_out) & sen));
            if (sclk_out[lane] && !sclk_prev[lane])
               rx_word <= {rx_word[radio_pkg::spi_bits-2:0], mosi_out[lane]};
            if (!sclk_out[lane] && sclk_prev[lane] && tx_pos >= 0)
            begin
               miso_in <= '0;
               miso_in[lane] <= spi_resp[tx_pos];   // Next bit after falling SCLK
               tx_pos <= tx_pos - 1;
            end
         end
         sen_prev <= sen;
         sclk_prev <= sclk_out;
      end
   end

   ////////////////////
   // DAC stream comparer

   always @(posedge clk_2x)
   begin
      if (!rst_n)
      begin
         have_prev = 1'b0;
         q_pending = 1'b0;
      end
      else
      begin
         if (have_prev)
            check_bit("tx_sync", tx_sync, ~prev_sync);
         if (tx_sync)
         begin
            if (q_pending)
               check_dac("tx_data", tx_data, expected_word(cur_pair, 1'b1));
            else
               check_dac("tx_data", tx_data, '0);   // Silence after an idle I slot
            q_pending = 1'b0;
         end
         else if (tx_data != '0)
         begin
            if (sent_pairs.size() == 0)
               abort_run("DAC sent an I word that was never written");
            cur_pair = sent_pairs.pop_front();
            check_dac("tx_data", tx_data, expected_word(cur_pair, 1'b0));
            q_pending = 1'b1;
         end
         prev_sync = tx_sync;
         have_prev = 1'b1;
      end
   end

   ////////////////////
   // Main sequence

   initial
   begin
      logic [31:0] rd;
      logic err;
      radio_pkg::reg_word_u cmd;
      radio_pkg::reg_word_u got;
      radio_pkg::reg_word_u exp;
      clk_2x = 1'b0;
      rst_n = 1'b0;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = '0;
      pwdata = '0;
      miso_in = '0;
      spi_resp = '0;
      repeat (5) @(posedge clk_2x);
      rst_n <= 1'b1;

      // Control register and decode errors
      apb_transfer(1'b1, radio_pkg::addr_tx_ctrl, 32'h1, rd, err);
      check_bit("pslverr", err, 1'b0);
      apb_transfer(1'b0, radio_pkg::addr_tx_ctrl, '0, rd, err);
      got = rd & 32'h3;   // Bit 2 depends on the DAC phase here
      check_word("prdata", got, 32'h3);
      stop_tx();
      apb_transfer(1'b0, 8'h24, '0, rd, err);
      check_bit("pslverr", err, 1'b1);

      // One transfer per chip writes and reads at once
      for (int chip = 0; chip < radio_pkg::spi_slaves; chip++)
      begin
         cmd = $random(seed);
         cmd.spi_cmd.spare = '0;
         cmd.spi_cmd.chip = chip[1:0];
         spi_resp = $random(seed);
         apb_transfer(1'b1, radio_pkg::addr_spi_cmd, cmd, rd, err);
         check_bit("pslverr", err, 1'b0);
         apb_transfer(1'b1, radio_pkg::addr_spi_cmd, cmd, rd, err);   // Still busy
         check_bit("pslverr", err, 1'b1);
         wait_spi_idle();
         got = '0;
         exp = '0;
         got.spi_cmd.data = rx_word;
         exp.spi_cmd.data = cmd.spi_cmd.data;
         check_word("mosi_out", got, exp);
         for (int k = 0; k < radio_pkg::spi_slaves; k++)
            check_bit("sen", sen_low_seen[k], k == chip);
         check_bit("idle lane activity", idle_busy, 1'b0);
         apb_transfer(1'b0, radio_pkg::addr_spi_rdata, '0, rd, err);
         exp = '0;
         exp.spi_cmd.data = spi_expected(spi_resp);
         check_word("prdata", rd, exp);
      end

      // DAC stream and the underrun once it drains
      for (int i = 0; i < 6; i++)
         write_pair(1'b1);
      apb_transfer(1'b1, radio_pkg::addr_tx_ctrl, 32'h1, rd, err);
      wait_drained();
      wait_underrun();
      apb_transfer(1'b0, radio_pkg::addr_tx_ctrl, '0, rd, err);
      check_word("prdata", rd, 32'h7);
      stop_tx();

      // Full FIFO rejects the ninth pair
      for (int i = 0; i < radio_pkg::fifo_depth - 1; i++)
         write_pair(1'b1);
      check_bit("tx_have_space", tx_have_space, 1'b1);
      write_pair(1'b1);
      apb_transfer(1'b0, radio_pkg::addr_tx_ctrl, '0, rd, err);
      check_word("prdata", rd, 32'h0);
      check_bit("tx_have_space", tx_have_space, 1'b0);
      write_pair(1'b0);
      apb_transfer(1'b1, radio_pkg::addr_tx_ctrl, 32'h1, rd, err);
      wait_drained();
      wait_underrun();
      stop_tx();

      $display(">>> PASS");
      $finish;
   end

endmodule

//--- list.f
hw/radio_pkg.sv
hw/apb_regs.sv
hw/spi_master.sv
hw/tx_sample_fifo.sv
hw/dac_interleave.sv
hw/radio_io_top.sv
verif/radio_io_sva.sv
verif/radio_io_tb.sv

//--- Bender.yml
package:
  name: radio_io

sources:
  - hw/radio_pkg.sv
  - hw/apb_regs.sv
  - hw/spi_master.sv
  - hw/tx_sample_fifo.sv
  - hw/dac_interleave.sv
  - hw/radio_io_top.sv
  - target: simulation
    files:
      - verif/radio_io_sva.sv
      - verif/radio_io_tb.sv
